/* src/mul_cfg_pkg.sv */
// Widths, fixed-point position and step sizing shared by the multiplier RTL and its testbench
`default_nettype none

package mul_cfg_pkg;

    // Operand and result width
    localparam int WIDTH = 16;
    localparam int FRAC_BITS = 8;

    // Radix-4 digits per step, two multiplier bits each
    localparam int DIGITS_PER_STEP = 4;
    localparam int BITS_PER_STEP = 2 * DIGITS_PER_STEP;
    localparam int NUM_STEPS = WIDTH / BITS_PER_STEP;

    // New upper product plus the retired low bits of one step
    localparam int PP_WIDTH = WIDTH + BITS_PER_STEP;

    typedef logic [WIDTH-1:0] operand_t;
    typedef logic [2*WIDTH-1:0] product_t;
    typedef logic [PP_WIDTH-1:0] partial_t;

endpackage

`default_nettype wire

/* src/mul_ctrl_pkg.sv */
// Sequencer state and step-counter types for the multiplier control path
`default_nettype none

package mul_ctrl_pkg;

    typedef enum logic [1:0] {
        MUL_IDLE = 2'd0,
        MUL_CALC = 2'd1,
        MUL_DONE = 2'd2
    } mul_state_t;

    // Holds 0 .. NUM_STEPS
    typedef logic [$clog2(mul_cfg_pkg::NUM_STEPS + 1)-1:0] step_cnt_t;

endpackage

`default_nettype wire

/* src/radix4_partial_product.sv */
// Combinational radix-4 digit array that adds one step of multiplier digits to the upper product
`timescale 1ns/1ps
`default_nettype none

module radix4_partial_product
    import mul_cfg_pkg::*;
(
    input  operand_t                 multiplicand,
    input  logic [BITS_PER_STEP-1:0] digits,
    input  operand_t                 acc_high,
    output partial_t                 partial
);

    // Two extra bits hold acc plus 3x multiplicand
    logic [WIDTH+1:0] mult_x1;
    logic [WIDTH+1:0] mult_x2;
    logic [WIDTH+1:0] mult_x3;
    logic [WIDTH+1:0] row_sum [DIGITS_PER_STEP];

    assign mult_x1 = {2'b00, multiplicand};
    assign mult_x2 = {1'b0, multiplicand, 1'b0};
    assign mult_x3 = mult_x1 + mult_x2;

    for (genvar i = 0; i < DIGITS_PER_STEP; i++) begin : g_row
        logic [1:0]       digit;
        logic [WIDTH+1:0] row_add;
        logic [WIDTH+1:0] row_in;

        assign digit = digits[2*i +: 2];

        always_comb begin
            case (digit)
                2'b00:   row_add = '0;
                2'b01:   row_add = mult_x1;
                2'b10:   row_add = mult_x2;
                default: row_add = mult_x3;
            endcase
        end

        // Each row sees the previous sum with its two retired bits dropped
        if (i == 0) begin : g_first
            assign row_in = {2'b00, acc_high};
        end else begin : g_chain
            assign row_in = {2'b00, row_sum[i-1][WIDTH+1:2]};
        end

        assign row_sum[i] = row_in + row_add;
    end

    always_comb begin
        partial[PP_WIDTH-1:BITS_PER_STEP] = row_sum[DIGITS_PER_STEP-1][WIDTH+1:2];
        for (int k = 0; k < DIGITS_PER_STEP; k++) begin
            partial[2*k +: 2] = row_sum[k][1:0];
        end
    end

    // Result bounded by acc + multiplicand * digits
    always_comb begin
        if (!$isunknown({multiplicand, digits, acc_high})) begin
            a_partial_bound: assert final (product_t'(partial) <=
                product_t'(acc_high) + product_t'(multiplicand) * product_t'(digits))
            else $error("radix4_partial_product: partial product out of range");
        end
    end

endmodule

`default_nettype wire

/* src/mul_datapath.sv */
// Multiplier datapath holding operands and the shifting product, and registering the result
`timescale 1ns/1ps
`default_nettype none

module mul_datapath
    import mul_cfg_pkg::*;
(
    input  logic     ctl_clk,
    input  logic     reset,
    input  operand_t a,
    input  operand_t b,
    input  logic     load,
    input  logic     step,
    input  logic     capture,
    output operand_t y
);

    operand_t multiplicand_reg;
    product_t prod_reg;
    partial_t partial;

    // Upper half accumulates, lower half shifts out multiplier digits
    radix4_partial_product u_radix4_pp (
        .multiplicand (multiplicand_reg),
        .digits       (prod_reg[BITS_PER_STEP-1:0]),
        .acc_high     (prod_reg[2*WIDTH-1:WIDTH]),
        .partial      (partial)
    );

    always_ff @(posedge ctl_clk) begin
        if (load) begin
            multiplicand_reg <= a;
            prod_reg <= {operand_t'(0), b};
        end else if (step) begin
            // Retired bits land just below the new upper half
            prod_reg <= {partial, prod_reg[WIDTH-1:BITS_PER_STEP]};
        end
    end

    // Fixed-point window of the full product
    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            y <= '0;
        end else if (capture) begin
            y <= prod_reg[FRAC_BITS +: WIDTH];
        end
    end

    // Sequencer never loads while a step is in flight
    a_no_load_step: assert property (@(posedge ctl_clk) disable iff (!reset)
        !(load && step))
    else $error("mul_datapath: load and step high together");

endmodule

`default_nettype wire

/* src/mul_sequencer.sv */
// Multiplier control FSM that counts steps and drives the in_ready/out_valid handshake
`timescale 1ns/1ps
`default_nettype none

module mul_sequencer
    import mul_cfg_pkg::*;
    import mul_ctrl_pkg::*;
(
    input  logic ctl_clk,
    input  logic reset,
    input  logic in_valid,
    output logic in_ready,
    output logic load,
    output logic step,
    output logic capture,
    output logic out_valid
);

    mul_state_t state;
    mul_state_t state_next;
    step_cnt_t  step_cnt;

    // Accept
    assign load = in_valid && in_ready;

    always_comb begin
        state_next = state;
        case (state)
            MUL_IDLE: begin
                if (load) begin
                    state_next = MUL_CALC;
                end
            end
            MUL_CALC: begin
                if (step_cnt == step_cnt_t'(NUM_STEPS - 1)) begin
                    state_next = MUL_DONE;
                end
            end
            MUL_DONE: begin
                state_next = load ? MUL_CALC : MUL_IDLE;
            end
            default: begin
                state_next = MUL_IDLE;
            end
        endcase
    end

    always_ff @(posedge ctl_clk) begin
        if (!reset) begin
            state <= MUL_IDLE;
            step_cnt <= '0;
            in_ready <= 1'b1;
            step <= 1'b0;
            capture <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            state <= state_next;
            in_ready <= (state_next != MUL_CALC);
            step <= (state_next == MUL_CALC);
            capture <= (state_next == MUL_DONE);
            out_valid <= capture;
            if (load) begin
                step_cnt <= '0;
            end else if (state == MUL_CALC) begin
                step_cnt <= step_cnt + 1'b1;
            end
        end
    end

    // One pulse per result even back to back
    a_single_pulse: assert property (@(posedge ctl_clk) disable iff (!reset)
        out_valid |=> !out_valid)
    else $error("mul_sequencer: out_valid high two cycles in a row");

    // No new accept during the step cycles of a running multiplication
    a_no_load_in_calc: assert property (@(posedge ctl_clk) disable iff (!reset)
        load |=> !load [*NUM_STEPS])
    else $error("mul_sequencer: operands accepted while busy");

endmodule

`default_nettype wire

/* src/fixed_mul_radix4.sv */
// Top level of the sequential radix-4 fixed-point multiplier, joining control and datapath
`timescale 1ns/1ps
`default_nettype none

module fixed_mul_radix4
    import mul_cfg_pkg::*;
(
    input  logic     ctl_clk,
    input  logic     reset,
    input  operand_t a,
    input  operand_t b,
    input  logic     in_valid,
    output logic     in_ready,
    output operand_t y,
    output logic     out_valid
);

    logic load;
    logic step;
    logic capture;

    mul_sequencer u_sequencer (
        .ctl_clk   (ctl_clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .load      (load),
        .step      (step),
        .capture   (capture),
        .out_valid (out_valid)
    );

    mul_datapath u_datapath (
        .ctl_clk (ctl_clk),
        .reset   (reset),
        .a       (a),
        .b       (b),
        .load    (load),
        .step    (step),
        .capture (capture),
        .y       (y)
    );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
// Testbench clock and reset source, instantiated by the multiplier testbench top
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic ctl_clk,
    output logic reset
);

    localparam real PERIOD_NS = 4.0;
    localparam int RESET_CYCLES = 5;

    initial begin
        ctl_clk = 1'b0;
        forever #(PERIOD_NS / 2.0) ctl_clk = ~ctl_clk;
    end

    // Active low, released after the fifth rising edge
    initial begin
        reset = 1'b0;
        repeat (RESET_CYCLES) @(posedge ctl_clk);
        reset <= 1'b1;
    end

endmodule

`default_nettype wire

/* verif/tb_fixed_mul_radix4.sv */
// Self-checking testbench for the radix-4 fixed-point multiplier, run as the simulation top
`timescale 1ns/1ps
`default_nettype none

module tb_fixed_mul_radix4
    import mul_cfg_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 20;
    localparam int LATENCY = NUM_STEPS + 1;
    localparam int RANDOM_PAIRS = 40;

    logic     ctl_clk;
    logic     reset;
    operand_t a;
    operand_t b;
    logic     in_valid;
    logic     in_ready;
    operand_t y;
    logic     out_valid;

    int       cycle_cnt = 0;
    int       accept_cycle;
    int       value_errors;
    int       timeout_errors;
    integer   seed;
    operand_t tab_a [$];
    operand_t tab_b [$];
    operand_t tab_y [$];

    tb_clock_gen u_clock_gen (
        .ctl_clk (ctl_clk),
        .reset   (reset)
    );

    fixed_mul_radix4 uut (
        .ctl_clk   (ctl_clk),
        .reset     (reset),
        .a         (a),
        .b         (b),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .y         (y),
        .out_valid (out_valid)
    );

    // Edge count, read only at falling edges
    always @(posedge ctl_clk) cycle_cnt <= cycle_cnt + 1;

    // Full unsigned product, window from FRAC_BITS up
    function automatic operand_t fixed_product(input operand_t x, input operand_t yv);
        product_t wide_x;
        product_t full;
        wide_x = x;
        full = wide_x * yv;
        return full[FRAC_BITS +: WIDTH];
    endfunction

    task automatic add_entry(input operand_t x, input operand_t yv, input operand_t expected);
        tab_a.push_back(x);
        tab_b.push_back(yv);
        tab_y.push_back(expected);
    endtask

    task automatic load_vectors();
        add_entry(16'h0000, 16'h0000, 16'h0000);
        add_entry(16'h0000, 16'h1234, 16'h0000);
        add_entry(16'h0100, 16'h0100, 16'h0100);
        add_entry(16'h0080, 16'h0080, 16'h0040);
        add_entry(16'h0040, 16'h0300, 16'h00c0);
        // Multiplier digits all 3
        add_entry(16'h0123, 16'hffff, 16'h22fe);
        add_entry(16'h0100, 16'hffff, 16'hffff);
        add_entry(16'hffff, 16'hffff, 16'hfe00);
        // Truncated fraction, rounding would differ
        add_entry(16'h0001, 16'h00ff, 16'h0000);
        add_entry(16'h0180, 16'h0101, 16'h0181);
        // Integer part wider than the window
        add_entry(16'h2000, 16'h1000, 16'h0000);
        add_entry(16'h1234, 16'h5678, 16'h2600);
        add_entry(16'h00ff, 16'h5555, 16'h54ff);
        add_entry(16'haaaa, 16'h0003, 16'h01ff);
        add_entry(16'h8000, 16'h0002, 16'h0100);
    endtask

    task automatic compare_y(input operand_t x, input operand_t yv, input operand_t got,
                             input operand_t expected);
        if (got !== expected) begin
            $display("Fail at %0t: a=%h b=%h y=%h expected %h", $time, x, yv, got, expected);
            value_errors++;
        end
    endtask

    // Returns at the accept edge with in_valid dropped
    task automatic send_pair(input operand_t x, input operand_t yv);
        int waited;
        @(posedge ctl_clk);
        a <= x;
        b <= yv;
        in_valid <= 1'b1;
        waited = 0;
        @(negedge ctl_clk);
        while (!in_ready && waited < TIMEOUT_CYCLES) begin
            @(negedge ctl_clk);
            waited++;
        end
        if (!in_ready) begin
            $display("Timeout at %0t: in_ready never rose for a=%h b=%h", $time, x, yv);
            timeout_errors++;
        end
        accept_cycle = cycle_cnt + 1;
        @(posedge ctl_clk);
        in_valid <= 1'b0;
    endtask

    task automatic await_result(output operand_t result, output int seen_cycle, output bit seen);
        int waited;
        waited = 0;
        @(negedge ctl_clk);
        while (!out_valid && waited < TIMEOUT_CYCLES) begin
            @(negedge ctl_clk);
            waited++;
        end
        seen = out_valid;
        result = y;
        seen_cycle = cycle_cnt;
        if (!seen) begin
            $display("Timeout at %0t: no out_valid pulse within %0d cycles", $time, waited);
            timeout_errors++;
        end
    endtask

    task automatic check_latency(input operand_t x, input operand_t yv, input int edges);
        if (edges != LATENCY) begin
            $display("Fail at %0t: a=%h b=%h out_valid after %0d edges, expected %0d",
                     $time, x, yv, edges, LATENCY);
            value_errors++;
        end
    endtask

    task automatic run_single(input operand_t x, input operand_t yv, input operand_t expected);
        operand_t got;
        int       done_cycle;
        bit       seen;
        send_pair(x, yv);
        await_result(got, done_cycle, seen);
        if (seen) begin
            compare_y(x, yv, got, expected);
            check_latency(x, yv, done_cycle - accept_cycle);
            // Single pulse, y held afterwards
            @(negedge ctl_clk);
            if (out_valid || y !== got) begin
                $display("Fail at %0t: a=%h b=%h out_valid=%b y=%h after pulse",
                         $time, x, yv, out_valid, y);
                value_errors++;
            end
        end
    endtask

    // Junk operands offered while busy must not disturb the pending result
    task automatic hold_while_busy(input operand_t x, input operand_t yv,
                                   input operand_t expected);
        operand_t got;
        int       done_cycle;
        bit       seen;
        send_pair(x, yv);
        a <= ~x;
        b <= yv ^ 16'h5a5a;
        in_valid <= 1'b1;
        for (int i = 0; i < NUM_STEPS; i++) begin
            @(negedge ctl_clk);
            if (in_ready) begin
                $display("Fail at %0t: a=%h b=%h in_ready high during step %0d",
                         $time, x, yv, i);
                value_errors++;
            end
            @(posedge ctl_clk);
            a <= a + 16'h0101;
            if (i == NUM_STEPS - 1) begin
                in_valid <= 1'b0;
            end
        end
        await_result(got, done_cycle, seen);
        if (seen) begin
            compare_y(x, yv, got, expected);
            check_latency(x, yv, done_cycle - accept_cycle);
        end
    endtask

    // Whole table with in_valid held high between pairs
    task automatic stream_table();
        operand_t a_q [$];
        operand_t b_q [$];
        operand_t exp_q [$];
        int       prev_accept;
        fork
            begin : sender
                int waited;
                @(posedge ctl_clk);
                for (int i = 0; i < tab_a.size(); i++) begin
                    a <= tab_a[i];
                    b <= tab_b[i];
                    in_valid <= 1'b1;
                    waited = 0;
                    @(negedge ctl_clk);
                    while (!in_ready && waited < TIMEOUT_CYCLES) begin
                        @(negedge ctl_clk);
                        waited++;
                    end
                    if (!in_ready) begin
                        $display("Timeout at %0t: stream stalled at pair %0d", $time, i);
                        timeout_errors++;
                    end
                    if (i > 0 && cycle_cnt + 1 - prev_accept != LATENCY) begin
                        $display("Fail at %0t: pair %0d accepted %0d edges after the last",
                                 $time, i, cycle_cnt + 1 - prev_accept);
                        value_errors++;
                    end
                    prev_accept = cycle_cnt + 1;
                    a_q.push_back(tab_a[i]);
                    b_q.push_back(tab_b[i]);
                    exp_q.push_back(tab_y[i]);
                    @(posedge ctl_clk);
                end
                in_valid <= 1'b0;
            end
            begin : receiver
                operand_t got;
                int       done_cycle;
                bit       seen;
                for (int j = 0; j < tab_a.size(); j++) begin
                    await_result(got, done_cycle, seen);
                    if (seen && exp_q.size() > 0) begin
                        compare_y(a_q.pop_front(), b_q.pop_front(), got, exp_q.pop_front());
                    end
                end
            end
        join
    endtask

    initial begin
        operand_t ra;
        operand_t rb;
        int       waited;
        a = '0;
        b = '0;
        in_valid = 1'b0;
        value_errors = 0;
        timeout_errors = 0;
        seed = 87;
        load_vectors();

        waited = 0;
        @(negedge ctl_clk);
        while (!reset && waited < TIMEOUT_CYCLES) begin
            @(negedge ctl_clk);
            waited++;
        end
        if (!reset) begin
            $display("Timeout at %0t: reset was never released", $time);
            timeout_errors++;
        end
        if (!in_ready || out_valid || y !== '0) begin
            $display("Fail at %0t: after reset in_ready=%b out_valid=%b y=%h",
                     $time, in_ready, out_valid, y);
            value_errors++;
        end

        for (int i = 0; i < tab_a.size(); i++) begin
            run_single(tab_a[i], tab_b[i], tab_y[i]);
        end
        hold_while_busy(16'h0180, 16'h0101, 16'h0181);
        hold_while_busy(16'hffff, 16'hffff, 16'hfe00);
        stream_table();
        for (int n = 0; n < RANDOM_PAIRS; n++) begin
            ra = operand_t'($random(seed));
            rb = operand_t'($random(seed));
            run_single(ra, rb, fixed_product(ra, rb));
        end

        repeat (2) @(posedge ctl_clk);
        $display("Errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
        if (value_errors + timeout_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
src/mul_cfg_pkg.sv
src/mul_ctrl_pkg.sv
src/radix4_partial_product.sv
src/mul_datapath.sv
src/mul_sequencer.sv
src/fixed_mul_radix4.sv
verif/tb_clock_gen.sv
verif/tb_fixed_mul_radix4.sv

/* Bender.yml */
package:
  name: fixed_mul_radix4

sources:
  # Packages ahead of the modules that import them
  - src/mul_cfg_pkg.sv
  - src/mul_ctrl_pkg.sv
  - src/radix4_partial_product.sv
  - src/mul_datapath.sv
  - src/mul_sequencer.sv
  - src/fixed_mul_radix4.sv

  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/tb_fixed_mul_radix4.sv
